// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int XLEN = 32;

  // data, address or instruction word
  typedef logic [XLEN-1:0] word_t;
  // RV32E has sixteen registers
  typedef logic [3:0] reg_addr_t;

  // ==========================================================================
  // major opcodes
  // ==========================================================================
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // decoded operation, anything unknown is OP_NOP
  typedef enum logic [2:0] {
    OP_NOP,
    OP_ADD,
    OP_ADDI,
    OP_LUI,
    OP_JALR,
    OP_LW,
    OP_SW
  } op_kind_t;

  typedef struct packed {
    op_kind_t  op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
  } decoded_t;

  // request half of a memory port
  typedef struct packed {
    word_t addr;
    logic  wen;
    word_t wdata;
  } mem_req_t;

endpackage

// File: verilog/rv_core_ctrl.sv
`timescale 1ns/1ps

module rv_core_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_core_pkg::op_kind_t op,
  input  logic                  imem_req_ready,
  input  logic                  imem_resp_valid,
  input  logic                  dmem_req_ready,
  input  logic                  dmem_resp_valid,
  output logic                  imem_req_valid,
  output logic                  dmem_req_valid,
  output logic                  inst_load,
  output logic                  pc_advance,
  output logic                  rf_write
);

  typedef enum logic [2:0] {
    FETCH_REQ,
    FETCH_WAIT,
    EXECUTE,
    MEM_REQ,
    MEM_WAIT
  } ctrl_state_t;

  ctrl_state_t state;
  logic        mem_op;
  logic        writes_reg;

  assign mem_op     = (op == rv_core_pkg::OP_LW) || (op == rv_core_pkg::OP_SW);
  assign writes_reg = (op != rv_core_pkg::OP_SW) && (op != rv_core_pkg::OP_NOP);

  // ==========================================================================
  // state and request valids
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= FETCH_REQ;
      imem_req_valid <= 1'b0;
      dmem_req_valid <= 1'b0;
    end else begin
      case (state)
        FETCH_REQ: begin
          // valid rises here only on the way out of reset
          if (imem_req_valid && imem_req_ready) begin
            imem_req_valid <= 1'b0;
            state          <= FETCH_WAIT;
          end else begin
            imem_req_valid <= 1'b1;
          end
        end
        FETCH_WAIT: begin
          if (imem_resp_valid) begin
            state <= EXECUTE;
          end
        end
        EXECUTE: begin
          if (mem_op) begin
            dmem_req_valid <= 1'b1;
            state          <= MEM_REQ;
          end else begin
            imem_req_valid <= 1'b1;
            state          <= FETCH_REQ;
          end
        end
        MEM_REQ: begin
          if (dmem_req_ready) begin
            dmem_req_valid <= 1'b0;
            state          <= MEM_WAIT;
          end
        end
        MEM_WAIT: begin
          if (dmem_resp_valid) begin
            imem_req_valid <= 1'b1;
            state          <= FETCH_REQ;
          end
        end
        default: state <= FETCH_REQ;
      endcase
    end
  end

  // one-cycle strobes
  assign inst_load  = (state == FETCH_WAIT) && imem_resp_valid;
  assign pc_advance = ((state == EXECUTE) && !mem_op)
                    || ((state == MEM_WAIT) && dmem_resp_valid);
  // loads write back on the response, everything else in EXECUTE
  assign rf_write   = ((state == EXECUTE) && !mem_op && writes_reg)
                    || ((state == MEM_WAIT) && dmem_resp_valid
                        && (op == rv_core_pkg::OP_LW));

endmodule

// File: verilog/pc_counter.sv
`timescale 1ns/1ps

module pc_counter #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h3000_0000
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               pc_advance,
  input  rv_core_pkg::word_t next_pc,
  output rv_core_pkg::word_t pc
);

  // next_pc is either pc + 4 or a jump target
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (pc_advance) begin
      pc <= next_pc;
    end
  end

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_load,
  input  rv_core_pkg::word_t    imem_rdata,
  output rv_core_pkg::decoded_t dec
);

  rv_core_pkg::word_t inst;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;

  // instruction register, all zero decodes as a no-op
  always_ff @(posedge clk) begin
    if (rst) begin
      inst <= '0;
    end else if (inst_load) begin
      inst <= imem_rdata;
    end
  end

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // RV32E only has x0..x15, so the top bit of each field is dropped
  assign dec.rd  = inst[10:7];
  assign dec.rs1 = inst[18:15];
  assign dec.rs2 = inst[23:20];

  // ==========================================================================
  // operation and immediate
  // ==========================================================================
  always_comb begin
    dec.op  = rv_core_pkg::OP_NOP;
    dec.imm = '0;
    case (opcode)
      rv_core_pkg::OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) dec.op = rv_core_pkg::OP_ADD;
      end
      rv_core_pkg::OPC_OP_IMM: begin
        if (funct3 == 3'b000) dec.op = rv_core_pkg::OP_ADDI;
        dec.imm = {{20{inst[31]}}, inst[31:20]};
      end
      rv_core_pkg::OPC_LUI: begin
        dec.op  = rv_core_pkg::OP_LUI;
        dec.imm = {inst[31:12], 12'b0};
      end
      rv_core_pkg::OPC_JALR: begin
        if (funct3 == 3'b000) dec.op = rv_core_pkg::OP_JALR;
        dec.imm = {{20{inst[31]}}, inst[31:20]};
      end
      rv_core_pkg::OPC_LOAD: begin
        if (funct3 == 3'b010) dec.op = rv_core_pkg::OP_LW;
        dec.imm = {{20{inst[31]}}, inst[31:20]};
      end
      rv_core_pkg::OPC_STORE: begin
        // S-type splits the offset around rs2
        if (funct3 == 3'b010) dec.op = rv_core_pkg::OP_SW;
        dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int NUM_REGS = 16
) (
  input  logic                        clk,
  input  logic                        we,
  input  logic [$clog2(NUM_REGS)-1:0] waddr,
  input  logic [$clog2(NUM_REGS)-1:0] raddr_1,
  input  logic [$clog2(NUM_REGS)-1:0] raddr_2,
  input  logic [31:0]                 wdata,
  output logic [31:0]                 rdata_1,
  output logic [31:0]                 rdata_2
);

  logic [31:0] regs [NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads, x0 forced to zero
  assign rdata_1 = (raddr_1 == '0) ? 32'b0 : regs[raddr_1];
  assign rdata_2 = (raddr_2 == '0) ? 32'b0 : regs[raddr_2];

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  rv_core_pkg::decoded_t dec,
  input  rv_core_pkg::word_t    pc,
  input  rv_core_pkg::word_t    rs1_val,
  input  rv_core_pkg::word_t    rs2_val,
  input  rv_core_pkg::word_t    load_data,
  output rv_core_pkg::word_t    rd_wdata,
  output rv_core_pkg::word_t    next_pc,
  output rv_core_pkg::mem_req_t dmem_req
);

  rv_core_pkg::word_t operand_b;
  rv_core_pkg::word_t sum;
  rv_core_pkg::word_t alu_result;
  rv_core_pkg::word_t pc_plus_4;

  // only add uses rs2 as the second operand
  assign operand_b  = (dec.op == rv_core_pkg::OP_ADD) ? rs2_val : dec.imm;
  assign sum        = rs1_val + operand_b;
  assign alu_result = (dec.op == rv_core_pkg::OP_LUI) ? dec.imm : sum;
  assign pc_plus_4  = pc + 32'd4;

  // jalr target with bit 0 cleared
  assign next_pc = (dec.op == rv_core_pkg::OP_JALR) ? {sum[31:1], 1'b0} : pc_plus_4;

  always_comb begin
    case (dec.op)
      rv_core_pkg::OP_JALR: rd_wdata = pc_plus_4;
      rv_core_pkg::OP_LW:   rd_wdata = load_data;
      default:              rd_wdata = alu_result;
    endcase
  end

  // ==========================================================================
  // data request, held stable by the instruction register
  // ==========================================================================
  assign dmem_req.addr  = sum;
  assign dmem_req.wen   = (dec.op == rv_core_pkg::OP_SW);
  assign dmem_req.wdata = rs2_val;

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter rv_core_pkg::word_t RESET_PC = 32'h3000_0000
) (
  input  logic                  clk,
  input  logic                  rst,
  // instruction port
  output rv_core_pkg::mem_req_t imem_req,
  output logic                  imem_req_valid,
  input  logic                  imem_req_ready,
  input  logic                  imem_resp_valid,
  input  rv_core_pkg::word_t    imem_rdata,
  // data port
  output rv_core_pkg::mem_req_t dmem_req,
  output logic                  dmem_req_valid,
  input  logic                  dmem_req_ready,
  input  logic                  dmem_resp_valid,
  input  rv_core_pkg::word_t    dmem_rdata
);

  rv_core_pkg::word_t    pc;
  rv_core_pkg::word_t    next_pc;
  rv_core_pkg::word_t    rs1_val;
  rv_core_pkg::word_t    rs2_val;
  rv_core_pkg::word_t    rd_wdata;
  rv_core_pkg::decoded_t dec;
  logic                  inst_load;
  logic                  pc_advance;
  logic                  rf_write;

  // fetches are always reads
  assign imem_req = '{addr: pc, wen: 1'b0, wdata: '0};

  rv_core_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .op              (dec.op),
    .imem_req_ready  (imem_req_ready),
    .imem_resp_valid (imem_resp_valid),
    .dmem_req_ready  (dmem_req_ready),
    .dmem_resp_valid (dmem_resp_valid),
    .imem_req_valid  (imem_req_valid),
    .dmem_req_valid  (dmem_req_valid),
    .inst_load       (inst_load),
    .pc_advance      (pc_advance),
    .rf_write        (rf_write)
  );

  pc_counter #(.RESET_PC(RESET_PC)) u_pc (
    .clk        (clk),
    .rst        (rst),
    .pc_advance (pc_advance),
    .next_pc    (next_pc),
    .pc         (pc)
  );

  inst_decoder u_dec (
    .clk        (clk),
    .rst        (rst),
    .inst_load  (inst_load),
    .imem_rdata (imem_rdata),
    .dec        (dec)
  );

  reg_file #(.NUM_REGS(16)) u_rf (
    .clk     (clk),
    .we      (rf_write),
    .waddr   (dec.rd),
    .raddr_1 (dec.rs1),
    .raddr_2 (dec.rs2),
    .wdata   (rd_wdata),
    .rdata_1 (rs1_val),
    .rdata_2 (rs2_val)
  );

  exec_unit u_exec (
    .dec       (dec),
    .pc        (pc),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .load_data (dmem_rdata),
    .rd_wdata  (rd_wdata),
    .next_pc   (next_pc),
    .dmem_req  (dmem_req)
  );

endmodule

// File: sim/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker (
  input logic                  clk,
  input logic                  rst,
  input rv_core_pkg::mem_req_t imem_req,
  input logic                  imem_req_valid,
  input logic                  imem_req_ready,
  input logic                  imem_resp_valid,
  input rv_core_pkg::mem_req_t dmem_req,
  input logic                  dmem_req_valid,
  input logic                  dmem_req_ready,
  input logic                  dmem_resp_valid
);

  logic imem_pending;
  logic dmem_pending;
  int   assert_failures = 0;

  // accepted requests still waiting for their response
  always_ff @(posedge clk) begin
    if (rst) begin
      imem_pending <= 1'b0;
      dmem_pending <= 1'b0;
    end else begin
      if (imem_req_valid && imem_req_ready) imem_pending <= 1'b1;
      else if (imem_resp_valid) imem_pending <= 1'b0;
      if (dmem_req_valid && dmem_req_ready) dmem_pending <= 1'b1;
      else if (dmem_resp_valid) dmem_pending <= 1'b0;
    end
  end

  // ==========================================================================
  // handshake rules
  // ==========================================================================
  imem_hold: assert property (@(posedge clk) disable iff (rst)
      imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req))
    else begin
      $error("instruction request changed while stalled");
      assert_failures++;
    end

  dmem_hold: assert property (@(posedge clk) disable iff (rst)
      dmem_req_valid && !dmem_req_ready |=> dmem_req_valid && $stable(dmem_req))
    else begin
      $error("data request changed while stalled");
      assert_failures++;
    end

  imem_resp_ok: assert property (@(posedge clk) disable iff (rst)
      imem_resp_valid |-> imem_pending)
    else begin
      $error("instruction response without a request");
      assert_failures++;
    end

  dmem_resp_ok: assert property (@(posedge clk) disable iff (rst)
      dmem_resp_valid |-> dmem_pending)
    else begin
      $error("data response without a request");
      assert_failures++;
    end

  one_valid: assert property (@(posedge clk) disable iff (rst)
      !(imem_req_valid && dmem_req_valid))
    else begin
      $error("both request valids high");
      assert_failures++;
    end

endmodule

bind rv_core rv_core_checker u_checker (
  .clk             (clk),
  .rst             (rst),
  .imem_req        (imem_req),
  .imem_req_valid  (imem_req_valid),
  .imem_req_ready  (imem_req_ready),
  .imem_resp_valid (imem_resp_valid),
  .dmem_req        (dmem_req),
  .dmem_req_valid  (dmem_req_valid),
  .dmem_req_ready  (dmem_req_ready),
  .dmem_resp_valid (dmem_resp_valid)
);

// File: sim/rv_core_monitor.sv
`timescale 1ns/1ps

module rv_core_monitor #(
  parameter rv_core_pkg::word_t RESET_PC   = 32'h3000_0000,
  parameter int                 PROG_LEN   = 18,
  parameter int                 NUM_STORES = 5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_core_pkg::mem_req_t imem_req,
  input  logic                  imem_req_valid,
  input  logic                  imem_req_ready,
  input  rv_core_pkg::mem_req_t dmem_req,
  input  logic                  dmem_req_valid,
  input  logic                  dmem_req_ready,
  input  int                    exp_next [PROG_LEN],
  input  rv_core_pkg::word_t    exp_st_addr [NUM_STORES],
  input  rv_core_pkg::word_t    exp_st_data [NUM_STORES],
  output int                    fetch_count,
  output int                    store_count,
  output int                    fetch_errors,
  output int                    store_errors
);

  int                 cur;
  rv_core_pkg::word_t exp_pc;

  // table index of the next fetch
  assign exp_pc = RESET_PC + rv_core_pkg::word_t'(cur * 4);

  always @(posedge clk) begin
    if (rst) begin
      cur          <= 0;
      fetch_count  <= 0;
      store_count  <= 0;
      fetch_errors <= 0;
      store_errors <= 0;
    end else begin
      if (imem_req_valid && imem_req_ready) begin
        // fetches are reads from the expected pc
        if (imem_req.addr !== exp_pc || imem_req.wen !== 1'b0) begin
          $display("[ERROR] %0t: fetch %0d from %h wen %b, expected a read from %h",
                   $time, fetch_count, imem_req.addr, imem_req.wen, exp_pc);
          fetch_errors <= fetch_errors + 1;
        end
        cur         <= exp_next[cur];
        fetch_count <= fetch_count + 1;
      end
      // stores are compared in program order
      if (dmem_req_valid && dmem_req_ready && dmem_req.wen) begin
        if (store_count >= NUM_STORES) begin
          $display("[ERROR] %0t: extra store of %h to %h",
                   $time, dmem_req.wdata, dmem_req.addr);
          store_errors <= store_errors + 1;
        end else if (dmem_req.addr !== exp_st_addr[store_count]
                     || dmem_req.wdata !== exp_st_data[store_count]) begin
          $display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
                   $time, store_count, dmem_req.wdata, dmem_req.addr,
                   exp_st_data[store_count], exp_st_addr[store_count]);
          store_errors <= store_errors + 1;
        end
        store_count <= store_count + 1;
      end
    end
  end

endmodule

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam rv_core_pkg::word_t RESET_PC = 32'h3000_0000;
  localparam int PROG_LEN   = 18;
  localparam int NUM_STORES = 5;
  localparam int TIMEOUT    = PROG_LEN * 12 + 50;

  // one program word with its successor and the store it should produce
  typedef struct packed {
    rv_core_pkg::word_t inst;
    logic [4:0]         next_idx;
    logic               store;
    rv_core_pkg::word_t st_addr;
    rv_core_pkg::word_t st_data;
  } prog_row_t;

  logic                  clk;
  logic                  rst;
  rv_core_pkg::mem_req_t imem_req;
  logic                  imem_req_valid;
  logic                  imem_req_ready;
  logic                  imem_resp_valid;
  rv_core_pkg::word_t    imem_rdata;
  rv_core_pkg::mem_req_t dmem_req;
  logic                  dmem_req_valid;
  logic                  dmem_req_ready;
  logic                  dmem_resp_valid;
  rv_core_pkg::word_t    dmem_rdata;

  prog_row_t          prog [PROG_LEN];
  int                 exp_next [PROG_LEN];
  rv_core_pkg::word_t exp_st_addr [NUM_STORES];
  rv_core_pkg::word_t exp_st_data [NUM_STORES];
  rv_core_pkg::word_t data_mem [rv_core_pkg::word_t];
  integer             seed = 32'h1f2b;
  int                 cycles;
  int                 fetch_count;
  int                 store_count;
  int                 fetch_errors;
  int                 store_errors;

  rv_core uut (.*);

  rv_core_monitor #(
    .RESET_PC   (RESET_PC),
    .PROG_LEN   (PROG_LEN),
    .NUM_STORES (NUM_STORES)
  ) monitor (
    .clk            (clk),
    .rst            (rst),
    .imem_req       (uut.imem_req),
    .imem_req_valid (uut.imem_req_valid),
    .imem_req_ready (uut.imem_req_ready),
    .dmem_req       (uut.dmem_req),
    .dmem_req_valid (uut.dmem_req_valid),
    .dmem_req_ready (uut.dmem_req_ready),
    .exp_next       (exp_next),
    .exp_st_addr    (exp_st_addr),
    .exp_st_data    (exp_st_data),
    .fetch_count    (fetch_count),
    .store_count    (store_count),
    .fetch_errors   (fetch_errors),
    .store_errors   (store_errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) cycles <= 0;
    else cycles <= cycles + 1;
  end

  // ==========================================================================
  // instruction encoding
  // ==========================================================================
  function automatic rv_core_pkg::word_t encode_i(input logic [11:0] imm,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_core_pkg::word_t encode_s(input logic [11:0] imm,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
      input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic rv_core_pkg::word_t encode_u(input logic [19:0] imm,
      input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_core_pkg::word_t encode_r(input logic [6:0] f7,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  task automatic set_row(input int idx, input rv_core_pkg::word_t inst, input int next_idx);
    prog[idx] = '{inst, 5'(next_idx), 1'b0, 32'h0, 32'h0};
  endtask

  task automatic set_store(input int idx, input rv_core_pkg::word_t inst,
      input rv_core_pkg::word_t addr, input rv_core_pkg::word_t data);
    prog[idx] = '{inst, 5'(idx + 1), 1'b1, addr, data};
  endtask

  // ==========================================================================
  // program and data tables
  // ==========================================================================
  task automatic load_program();
    int n;
    set_row(0, encode_u(20'h00010, 5'd1, rv_core_pkg::OPC_LUI), 1);
    set_row(1, encode_u(20'h12345, 5'd2, rv_core_pkg::OPC_LUI), 2);
    set_row(2, encode_i(12'h678, 5'd2, 3'b000, 5'd2, rv_core_pkg::OPC_OP_IMM), 3);
    set_store(3, encode_s(12'h000, 5'd2, 5'd1, 3'b010, rv_core_pkg::OPC_STORE),
              32'h0001_0000, 32'h1234_5678);
    // x3 = -5, then 0x1234_5678 - 5
    set_row(4, encode_i(12'hffb, 5'd0, 3'b000, 5'd3, rv_core_pkg::OPC_OP_IMM), 5);
    set_row(5, encode_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd4, rv_core_pkg::OPC_OP), 6);
    set_store(6, encode_s(12'h004, 5'd4, 5'd1, 3'b010, rv_core_pkg::OPC_STORE),
              32'h0001_0004, 32'h1234_5673);
    // load from the data table plus 0x11
    set_row(7, encode_i(12'h040, 5'd1, 3'b010, 5'd5, rv_core_pkg::OPC_LOAD), 8);
    set_row(8, encode_i(12'h011, 5'd5, 3'b000, 5'd6, rv_core_pkg::OPC_OP_IMM), 9);
    set_store(9, encode_s(12'h008, 5'd6, 5'd1, 3'b010, rv_core_pkg::OPC_STORE),
              32'h0001_0008, 32'hcafe_0111);
    // write to x0 must be lost
    set_row(10, encode_i(12'h007, 5'd3, 3'b000, 5'd0, rv_core_pkg::OPC_OP_IMM), 11);
    set_store(11, encode_s(12'h00c, 5'd0, 5'd1, 3'b010, rv_core_pkg::OPC_STORE),
              32'h0001_000c, 32'h0000_0000);
    // branch opcode, unsupported so it falls through
    // its rd bits name x1 so a stray write would move the last store
    set_row(12, encode_s(12'h001, 5'd2, 5'd2, 3'b000, 7'b1100011), 13);
    set_row(13, encode_u(20'h30000, 5'd9, rv_core_pkg::OPC_LUI), 14);
    // target 0x3000_0041 with bit 0 cleared skips row 15
    set_row(14, encode_i(12'h041, 5'd9, 3'b000, 5'd8, rv_core_pkg::OPC_JALR), 16);
    set_row(15, encode_i(12'h001, 5'd0, 3'b000, 5'd8, rv_core_pkg::OPC_OP_IMM), 16);
    set_store(16, encode_s(12'h010, 5'd8, 5'd1, 3'b010, rv_core_pkg::OPC_STORE),
              32'h0001_0010, 32'h3000_003c);
    // self-jump at 0x3000_0044
    set_row(17, encode_i(12'h044, 5'd9, 3'b000, 5'd0, rv_core_pkg::OPC_JALR), 17);
    data_mem[32'h0001_0040] = 32'hcafe_0100;
    n = 0;
    for (int i = 0; i < PROG_LEN; i++) begin
      exp_next[i] = int'(prog[i].next_idx);
      if (prog[i].store) begin
        exp_st_addr[n] = prog[i].st_addr;
        exp_st_data[n] = prog[i].st_data;
        n++;
      end
    end
  endtask

  // outside the program, an all-zero word decodes as a no-op
  function automatic rv_core_pkg::word_t fetch_word(input rv_core_pkg::word_t addr);
    rv_core_pkg::word_t off;
    off = addr - RESET_PC;
    if (off < rv_core_pkg::word_t'(PROG_LEN * 4)) return prog[off[6:2]].inst;
    return 32'h0;
  endfunction

  function automatic rv_core_pkg::word_t read_data(input rv_core_pkg::word_t addr);
    if (data_mem.exists(addr)) return data_mem[addr];
    return ~addr;
  endfunction

  // ==========================================================================
  // memory model with random ready and response delays
  // ==========================================================================
  task automatic serve_request(input logic is_data);
    rv_core_pkg::mem_req_t req;
    int                    delay;
    delay = {$random(seed)} % 4;
    repeat (delay) @(negedge clk);
    req = is_data ? dmem_req : imem_req;
    if (is_data) dmem_req_ready = 1'b1;
    else imem_req_ready = 1'b1;
    @(negedge clk);
    imem_req_ready = 1'b0;
    dmem_req_ready = 1'b0;
    delay = {$random(seed)} % 4;
    repeat (delay) @(negedge clk);
    if (!is_data) begin
      imem_rdata      = fetch_word(req.addr);
      imem_resp_valid = 1'b1;
    end else begin
      if (req.wen) data_mem[req.addr] = req.wdata;
      else dmem_rdata = read_data(req.addr);
      dmem_resp_valid = 1'b1;
    end
    @(negedge clk);
    imem_resp_valid = 1'b0;
    dmem_resp_valid = 1'b0;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (imem_req_valid) serve_request(1'b0);
        else if (dmem_req_valid) serve_request(1'b1);
      end
    end
  end

  initial begin
    int   missing;
    logic timed_out;
    rst             = 1'b1;
    imem_req_ready  = 1'b0;
    imem_resp_valid = 1'b0;
    imem_rdata      = '0;
    dmem_req_ready  = 1'b0;
    dmem_resp_valid = 1'b0;
    dmem_rdata      = '0;
    load_program();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    // run until the self-jump has been fetched a few times
    while (fetch_count < PROG_LEN + 2 && cycles < TIMEOUT) @(negedge clk);
    timed_out = (fetch_count < PROG_LEN + 2);
    missing   = (store_count < NUM_STORES) ? NUM_STORES - store_count : 0;
    $display("fetch errors %0d, store errors %0d, missing stores %0d, assertion failures %0d",
             fetch_errors, store_errors, missing, uut.u_checker.assert_failures);
    if (timed_out) begin
      $display("run timed out after %0d cycles with %0d fetches", cycles, fetch_count);
      $display("*** TEST FAILED ***");
    end else if (fetch_errors + store_errors + missing
                 + uut.u_checker.assert_failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: rv_core.f
verilog/rv_core_pkg.sv
verilog/rv_core_ctrl.sv
verilog/pc_counter.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_monitor.sv
sim/rv_core_tb.sv

// File: Makefile
# Verilator simulation of rv_core; every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_PATTERN ?= \*\*\* TEST PASSED \*\*\*

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_PATTERN)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
